//--- source/pov_params.svh
`ifndef POV_PARAMS_SVH
`define POV_PARAMS_SVH

// Slices displayed between two consecutive sensor tops
`define SLICES_PER_HALF_TURN 128

// Slices displayed over one full turn of the arm
`define SLICES_PER_TURN 256

// LEDs along the arm, one bit each in a column
`define LED_COUNT 16

// System clock rate in Hz, the base of the speed value
`define CLOCK_FREQUENCY 66000000

// Clock cycles spent at each level of led_clk
`define LED_CLK_HALF 1

`endif

//--- source/pov_pkg.sv
`default_nettype none

`include "pov_params.svh"

package pov_pkg;

    // Slice index over a full turn
    typedef logic [$clog2(`SLICES_PER_TURN)-1:0] slice_t;

    // One column of the image, the MSB is the first bit shifted out
    typedef logic [`LED_COUNT-1:0] column_t;

    // Half turns per second, halved so it reads as turns per second
    typedef logic [15:0] speed_t;

    // Host command that writes one column of the image
    typedef struct packed {
        slice_t  addr;
        column_t data;
    } column_wr_t;

    // Current position of the arm
    typedef struct packed {
        slice_t slice;
        // Set when the last top came from hall_2
        logic   second_half;
    } slice_pos_t;

endpackage

`default_nettype wire

//--- source/hall_sensor.sv
`timescale 1ns/100ps
`default_nettype none

`include "pov_params.svh"

module hall_sensor import pov_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       hall_1,
    input  logic       hall_2,
    output slice_pos_t slice_pos,
    output logic       position_sync,
    output speed_t     speed
);

    localparam int HALF_W = $clog2(`SLICES_PER_HALF_TURN);

    // Sensor levels registered once before the top detection
    logic hall_1_q;
    logic hall_2_q;
    // One-cycle pulse when a sensor first goes low
    logic top;
    // Held high from a top until both sensors read high again
    logic guard;
    // Which sensor gave the last top
    logic second_half;
    // Set once a first top has been seen, so that an interval exists
    logic top_seen;

    // Cycles since the last top, which saturates instead of wrapping
    logic [31:0] half_cycles;
    // Cycles between two slices, from the last measured half turn
    logic [31:0] slice_period;
    // Cycles spent in the current slice
    logic [31:0] slice_cycle;
    // Slice index within the current half turn
    logic [HALF_W-1:0] slice_half;

    // Both sensors pull low while a magnet passes, so idle is high
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hall_1_q <= 1'b1;
            hall_2_q <= 1'b1;
        end else begin
            hall_1_q <= hall_1;
            hall_2_q <= hall_2;
        end
    end

    // An unguarded low level gives one top and arms the guard
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            top         <= 1'b0;
            guard       <= 1'b0;
            second_half <= 1'b0;
        end else begin
            top <= 1'b0;
            if ((!hall_1_q || !hall_2_q) && !guard) begin
                top         <= 1'b1;
                guard       <= 1'b1;
                // hall_1 wins when both sensors fall together
                second_half <= hall_1_q;
            end
            // The guard only drops once both sensors are released
            if (hall_1_q && hall_2_q) begin
                guard <= 1'b0;
            end
        end
    end

    // Half turn measurement, slice period and speed
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            half_cycles  <= '0;
            slice_period <= '0;
            speed        <= '0;
            top_seen     <= 1'b0;
        end else if (top) begin
            // The count restarts at 1 so it equals the interval at the next top
            half_cycles <= 32'd1;
            top_seen    <= 1'b1;
            speed <= speed_t'((`CLOCK_FREQUENCY / (half_cycles + 32'd1)) / 2);
            // The first top after reset has no previous top to measure from
            if (top_seen) begin
                slice_period <= half_cycles >> HALF_W;
            end
        end else if (half_cycles != '1) begin
            half_cycles <= half_cycles + 32'd1;
        end
    end

    // Slice scheduler, a top restarts it and it stops at the last slice
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            position_sync <= 1'b0;
            slice_cycle   <= '0;
            slice_half    <= '0;
        end else begin
            position_sync <= 1'b0;
            if (top) begin
                slice_cycle   <= '0;
                slice_half    <= '0;
                position_sync <= 1'b1;
            end else if (slice_period != '0 &&
                         slice_half != HALF_W'(`SLICES_PER_HALF_TURN - 1)) begin
                if (slice_cycle == slice_period - 32'd1) begin
                    slice_cycle   <= '0;
                    slice_half    <= slice_half + 1'b1;
                    position_sync <= 1'b1;
                end else begin
                    slice_cycle <= slice_cycle + 32'd1;
                end
            end
        end
    end

    // The second half of the turn sits above the first in the image
    always_comb begin
        slice_pos.second_half = second_half;
        slice_pos.slice       = slice_t'(slice_half);
        if (second_half) begin
            slice_pos.slice = slice_t'(slice_half) + slice_t'(`SLICES_PER_HALF_TURN);
        end
    end

endmodule

`default_nettype wire

//--- source/stream_skid.sv
`timescale 1ns/100ps
`default_nettype none

module stream_skid #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     nrst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // High while the entry holds a payload
    logic     full;
    // Rises one cycle after reset so that nothing is accepted during reset
    logic     enable;
    // The stored payload
    payload_t data_q;

    // An empty entry accepts, so does a full one that drains this cycle
    assign in_ready  = enable && (!full || out_ready);
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            enable <= 1'b0;
            full   <= 1'b0;
        end else begin
            enable <= 1'b1;
            if (in_valid && in_ready) begin
                full <= 1'b1;
            end else if (out_ready) begin
                full <= 1'b0;
            end
        end
    end

    // Payload register, loaded on every accepted transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- source/column_memory.sv
`timescale 1ns/100ps
`default_nettype none

`include "pov_params.svh"

module column_memory import pov_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       wr_valid,
    output logic       wr_ready,
    input  column_wr_t wr,
    input  logic       rd_en,
    input  slice_t     rd_addr,
    output column_t    rd_data
);

    // One column per slice of the full turn
    column_t mem [`SLICES_PER_TURN];

    // Registered ready, high from the first cycle after reset
    logic ready_q;
    // A host write that completes this cycle
    logic wr_fire;
    // The read hits the column being written in the same cycle
    logic wr_hit;

    assign wr_ready = ready_q;
    assign wr_fire  = wr_valid && ready_q;
    assign wr_hit   = wr_fire && (wr.addr == rd_addr);

    // Writes never stall, so ready only waits for reset to end
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
        end
    end

    // Write port
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Read port, the data appears one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            // A write to the same column is forwarded so the read sees new data
            if (wr_hit) begin
                rd_data <= wr.data;
            end else begin
                rd_data <= mem[rd_addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/column_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module column_fetch import pov_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       position_sync,
    input  slice_pos_t slice_pos,
    output logic       rd_en,
    output slice_t     rd_addr,
    input  column_t    rd_data,
    output logic       col_valid,
    input  logic       col_ready,
    output column_t    col,
    output logic       overrun
);

    // A read was issued last cycle, its data is on rd_data now
    logic rd_pend;
    // A fetch is still in flight or its column has not been taken
    logic busy;

    // A column leaving this cycle no longer blocks a new sync
    assign busy    = rd_pend || (col_valid && !col_ready);
    assign rd_en   = position_sync && !busy;
    assign rd_addr = slice_pos.slice;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_pend   <= 1'b0;
            col_valid <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            rd_pend <= rd_en;
            // The column is offered the cycle after the memory returns it
            if (rd_pend) begin
                col_valid <= 1'b1;
            end else if (col_ready) begin
                col_valid <= 1'b0;
            end
            // Dropped syncs are remembered until the next reset
            if (position_sync && busy) begin
                overrun <= 1'b1;
            end
        end
    end

    // Column register, held until the downstream buffer takes it
    always_ff @(posedge clk) begin
        if (rd_pend) begin
            col <= rd_data;
        end
    end

endmodule

`default_nettype wire

//--- source/led_shifter.sv
`timescale 1ns/100ps
`default_nettype none

`include "pov_params.svh"

module led_shifter import pov_pkg::*; (
    input  logic    clk,
    input  logic    nrst,
    input  logic    col_valid,
    output logic    col_ready,
    input  column_t col,
    output logic    led_data,
    output logic    led_clk,
    output logic    led_latch
);

    localparam int BIT_W = $clog2(`LED_COUNT);

    typedef enum logic [1:0] {
        st_idle,
        st_shift,
        st_latch
    } shift_state_t;

    shift_state_t state;

    // Column bits still to be sent, the next one sits at the MSB
    column_t        shift_reg;
    // Index of the bit on led_data
    logic [BIT_W-1:0] bit_cnt;
    // Cycles spent at the current led_clk level
    logic [7:0]     half_cnt;
    // Last cycle of the current led_clk level
    logic           half_end;

    assign col_ready = (state == st_idle);
    assign half_end  = (half_cnt == 8'(`LED_CLK_HALF - 1));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= st_idle;
            bit_cnt   <= '0;
            half_cnt  <= '0;
            led_data  <= 1'b0;
            led_clk   <= 1'b0;
            led_latch <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    // The first bit goes out with led_clk low
                    if (col_valid) begin
                        state    <= st_shift;
                        bit_cnt  <= '0;
                        half_cnt <= '0;
                        led_data <= col[`LED_COUNT-1];
                        led_clk  <= 1'b0;
                    end
                end
                st_shift: begin
                    half_cnt <= half_cnt + 8'd1;
                    if (half_end) begin
                        half_cnt <= '0;
                        if (!led_clk) begin
                            // Rising edge, the driver samples led_data here
                            led_clk <= 1'b1;
                        end else if (bit_cnt == BIT_W'(`LED_COUNT - 1)) begin
                            led_clk   <= 1'b0;
                            led_latch <= 1'b1;
                            state     <= st_latch;
                        end else begin
                            // Falling edge moves to the next bit
                            led_clk  <= 1'b0;
                            led_data <= shift_reg[`LED_COUNT-2];
                            bit_cnt  <= bit_cnt + 1'b1;
                        end
                    end
                end
                st_latch: begin
                    // Latch pulse lasts one cycle, then a new column is taken
                    led_latch <= 1'b0;
                    led_data  <= 1'b0;
                    state     <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Shift register, loaded on accept and moved on every falling edge
    always_ff @(posedge clk) begin
        if (col_valid && col_ready) begin
            shift_reg <= col;
        end else if (state == st_shift && half_end && led_clk) begin
            shift_reg <= shift_reg << 1;
        end
    end

endmodule

`default_nettype wire

//--- source/pov_display.sv
`timescale 1ns/100ps
`default_nettype none

module pov_display import pov_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       hall_1,
    input  logic       hall_2,
    input  logic       wr_valid,
    output logic       wr_ready,
    input  column_wr_t wr,
    output slice_pos_t slice_pos,
    output logic       position_sync,
    output speed_t     speed,
    output logic       led_data,
    output logic       led_clk,
    output logic       led_latch,
    output logic       overrun
);

    // Host writes between the input buffer and the memory
    logic       mem_wr_valid;
    logic       mem_wr_ready;
    column_wr_t mem_wr;

    // Memory read port
    logic       rd_en;
    slice_t     rd_addr;
    column_t    rd_data;

    // Fetched columns, before and after the column buffer
    logic       fetch_col_valid;
    logic       fetch_col_ready;
    column_t    fetch_col;
    logic       led_col_valid;
    logic       led_col_ready;
    column_t    led_col;

    hall_sensor hall_sensor_i (
        .clk           (clk),
        .nrst          (nrst),
        .hall_1        (hall_1),
        .hall_2        (hall_2),
        .slice_pos     (slice_pos),
        .position_sync (position_sync),
        .speed         (speed)
    );

    // Buffer on the host write stream
    stream_skid #(.payload_t(column_wr_t)) wr_skid_i (
        .clk       (clk),
        .nrst      (nrst),
        .in_valid  (wr_valid),
        .in_ready  (wr_ready),
        .in_data   (wr),
        .out_valid (mem_wr_valid),
        .out_ready (mem_wr_ready),
        .out_data  (mem_wr)
    );

    column_memory column_memory_i (
        .clk      (clk),
        .nrst     (nrst),
        .wr_valid (mem_wr_valid),
        .wr_ready (mem_wr_ready),
        .wr       (mem_wr),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    column_fetch column_fetch_i (
        .clk           (clk),
        .nrst          (nrst),
        .position_sync (position_sync),
        .slice_pos     (slice_pos),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .col_valid     (fetch_col_valid),
        .col_ready     (fetch_col_ready),
        .col           (fetch_col),
        .overrun       (overrun)
    );

    // Buffer that holds one column while the LED chain is busy
    stream_skid #(.payload_t(column_t)) col_skid_i (
        .clk       (clk),
        .nrst      (nrst),
        .in_valid  (fetch_col_valid),
        .in_ready  (fetch_col_ready),
        .in_data   (fetch_col),
        .out_valid (led_col_valid),
        .out_ready (led_col_ready),
        .out_data  (led_col)
    );

    led_shifter led_shifter_i (
        .clk       (clk),
        .nrst      (nrst),
        .col_valid (led_col_valid),
        .col_ready (led_col_ready),
        .col       (led_col),
        .led_data  (led_data),
        .led_clk   (led_clk),
        .led_latch (led_latch)
    );

endmodule

`default_nettype wire

//--- verification/pov_display_checker.sv
`timescale 1ns/100ps
`default_nettype none

module pov_display_checker import pov_pkg::*; (
    input logic       clk,
    input logic       nrst,
    input logic       wr_valid,
    input logic       wr_ready,
    input column_wr_t wr,
    input logic       fetch_valid,
    input logic       fetch_ready,
    input column_t    fetch_col,
    input logic       led_col_valid,
    input logic       led_col_ready,
    input column_t    led_col,
    input logic       position_sync,
    input logic       led_clk,
    input logic       led_latch
);

    // Number of failed assertions so far
    int fail_count = 0;

    // The latch pulse lasts a single cycle
    assert property (@(posedge clk) disable iff (!nrst) led_latch |=> !led_latch)
    else begin
        $error("led_latch stayed high for more than one cycle");
        fail_count++;
    end

    // A stalled host command must not change
    assert property (@(posedge clk) disable iff (!nrst) wr_valid && !wr_ready |=> $stable(wr))
    else begin
        $error("host write command changed while stalled");
        fail_count++;
    end

    // Column offered by the fetch stage is held until the buffer takes it
    assert property (@(posedge clk) disable iff (!nrst)
                     fetch_valid && !fetch_ready |=> $stable(fetch_col))
    else begin
        $error("fetched column changed while stalled");
        fail_count++;
    end

    // Same rule on the buffer output towards the LED shifter
    assert property (@(posedge clk) disable iff (!nrst)
                     led_col_valid && !led_col_ready |=> $stable(led_col))
    else begin
        $error("buffered column changed while stalled");
        fail_count++;
    end

    // Syncs are single pulses
    assert property (@(posedge clk) disable iff (!nrst) position_sync |=> !position_sync)
    else begin
        $error("position_sync was high on two consecutive cycles");
        fail_count++;
    end

    // The driver latches with its shift clock low
    assert property (@(posedge clk) disable iff (!nrst) led_latch |-> !led_clk)
    else begin
        $error("led_clk was high during led_latch");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- verification/pov_display_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "pov_params.svh"

module pov_display_tb import pov_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    // Cycles between sensor tops in the slow and the fast runs
    localparam int HALF_SLOW = 5120;
    localparam int HALF_FAST = 1280;
    localparam int PULSE_LOW = 8;
    localparam int HOLD_LOW = 3000;
    localparam int SLOW_TURNS = 7;
    localparam int FAST_TURNS = 6;
    // Each host write takes at most two cycles including its random gap
    localparam int WRITE_CYCLES = 2 * `SLICES_PER_TURN + 20;
    localparam int WATCHDOG_CYCLES =
        WRITE_CYCLES + SLOW_TURNS * HALF_SLOW + FAST_TURNS * HALF_FAST + 1000;

    logic       clk = 1'b0;
    logic       nrst;
    logic       hall_1;
    logic       hall_2;
    logic       wr_valid;
    logic       wr_ready;
    column_wr_t wr;
    slice_pos_t slice_pos;
    logic       position_sync;
    speed_t     speed;
    logic       led_data;
    logic       led_clk;
    logic       led_latch;
    logic       overrun;

    // Image model with one random column per slice
    column_t image [`SLICES_PER_TURN];
    integer  seed = 34;
    int      errors = 0;
    // Number of the sensor that was pulsed last
    int      last_sensor = 1;

    // Sync timing bookkeeping in cycles counted at falling edges
    longint  cycle_count = 0;
    longint  last_top_cycle = 0;
    longint  last_sync_cycle = 0;
    bit      have_top = 0;
    int      exp_period = 0;
    int      half_syncs = 0;
    slice_t  last_slice;
    logic    top_half;
    int      tops = 0;
    int      speed_checks = 0;
    int      spacing_checks = 0;
    bit      saw_first_end = 0;
    bit      saw_second_end = 0;

    // Slices of syncs whose column has not been matched yet
    slice_t  sync_slices [$];
    // Column rebuilt from led_data
    column_t shifted = '0;
    int      bits = 0;
    logic    led_clk_q = 1'b0;
    int      columns = 0;
    bit      overrun_seen = 0;

    pov_display pov_display_i (
        .clk           (clk),
        .nrst          (nrst),
        .hall_1        (hall_1),
        .hall_2        (hall_2),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .wr            (wr),
        .slice_pos     (slice_pos),
        .position_sync (position_sync),
        .speed         (speed),
        .led_data      (led_data),
        .led_clk       (led_clk),
        .led_latch     (led_latch),
        .overrun       (overrun)
    );

    bind pov_display pov_display_checker checker_i (
        .clk           (clk),
        .nrst          (nrst),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .wr            (wr),
        .fetch_valid   (fetch_col_valid),
        .fetch_ready   (fetch_col_ready),
        .fetch_col     (fetch_col),
        .led_col_valid (led_col_valid),
        .led_col_ready (led_col_ready),
        .led_col       (led_col),
        .position_sync (position_sync),
        .led_clk       (led_clk),
        .led_latch     (led_latch)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic flag_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_test(input int number, input string name, input int start);
        $display("Test %0d %s: %0d errors", number, name, errors - start);
    endtask

    // Drives one host write and holds it until the DUT is ready
    task automatic write_column(input slice_t addr, input column_t data, output int waits);
        wr_valid = 1'b1;
        wr.addr  = addr;
        wr.data  = data;
        waits    = 0;
        while (!wr_ready && waits < 16) begin
            @(negedge clk);
            waits++;
        end
        if (!wr_ready) begin
            $display("Host write to column %0d was never accepted", addr);
            errors++;
        end
        @(negedge clk);
        wr_valid = 1'b0;
    endtask

    // Sensor pulses that start every interval cycles
    task automatic run_half_turns(input int sensor, input int count, input int interval,
                                  input int low_cycles);
        for (int n = 0; n < count; n++) begin
            last_sensor = sensor;
            if (sensor == 1) begin
                hall_1 = 1'b0;
            end else begin
                hall_2 = 1'b0;
            end
            repeat (low_cycles) @(negedge clk);
            hall_1 = 1'b1;
            hall_2 = 1'b1;
            repeat (interval - low_cycles) @(negedge clk);
        end
    endtask

    // Speed, spacing and slice order at each sync
    task automatic check_sync();
        int     interval;
        speed_t exp_speed;
        if (slice_pos.slice % `SLICES_PER_HALF_TURN == 0) begin
            tops++;
            assert (slice_pos.second_half == (last_sensor == 2))
            else flag_error($sformatf("second_half %0b after hall_%0d",
                                      slice_pos.second_half, last_sensor));
            exp_period = 0;
            if (have_top) begin
                interval  = int'(cycle_count - last_top_cycle);
                exp_speed = speed_t'((`CLOCK_FREQUENCY / (interval + 1)) / 2);
                speed_checks++;
                assert (speed == exp_speed)
                else flag_error($sformatf("speed %0d, expected %0d", speed, exp_speed));
                // Slice period is the half turn divided by 128
                exp_period = interval >> $clog2(`SLICES_PER_HALF_TURN);
            end
            have_top       = 1;
            last_top_cycle = cycle_count;
            half_syncs     = 1;
            top_half       = slice_pos.second_half;
        end else begin
            half_syncs++;
            spacing_checks++;
            assert (exp_period != 0)
            else flag_error("slice sync before any slice period was measured");
            assert (cycle_count - last_sync_cycle == exp_period)
            else flag_error($sformatf("sync spacing %0d, expected %0d",
                                      cycle_count - last_sync_cycle, exp_period));
            assert (slice_pos.slice == last_slice + 1'b1)
            else flag_error($sformatf("slice %0d after slice %0d", slice_pos.slice, last_slice));
            assert (slice_pos.second_half == top_half)
            else flag_error("second_half changed between tops");
            assert (half_syncs <= `SLICES_PER_HALF_TURN)
            else flag_error($sformatf("%0d syncs in one half turn", half_syncs));
        end
        assert ((slice_pos.slice >= `SLICES_PER_HALF_TURN) == slice_pos.second_half)
        else flag_error($sformatf("slice %0d in the wrong half", slice_pos.slice));
        if (slice_pos.slice == slice_t'(`SLICES_PER_HALF_TURN - 1)) begin
            saw_first_end = 1;
        end
        if (slice_pos.slice == slice_t'(`SLICES_PER_TURN - 1)) begin
            saw_second_end = 1;
        end
        last_slice      = slice_pos.slice;
        last_sync_cycle = cycle_count;
        sync_slices.push_back(slice_pos.slice);
    endtask

    // A latched column must equal the image at the oldest slice it can belong to
    task automatic check_column();
        slice_t s;
        bit     matched;
        int     skipped;
        matched = 0;
        skipped = 0;
        columns++;
        assert (bits == `LED_COUNT)
        else flag_error($sformatf("%0d bits shifted before the latch", bits));
        while (!matched && sync_slices.size() > 0) begin
            s = sync_slices.pop_front();
            if (image[s] == shifted) begin
                matched = 1;
            end else begin
                skipped++;
            end
        end
        assert (matched)
        else flag_error($sformatf("column %h matches no fetched slice", shifted));
        // Only a sync dropped under overrun may be passed over
        assert (skipped == 0 || overrun)
        else flag_error($sformatf("%0d slices skipped without overrun", skipped));
        bits = 0;
    endtask

    always @(negedge clk) begin
        cycle_count++;
        if (nrst) begin
            if (position_sync) begin
                check_sync();
            end
            // Bits are taken where led_clk has just risen
            if (led_clk && !led_clk_q) begin
                shifted = {shifted[`LED_COUNT-2:0], led_data};
                bits++;
            end
            if (led_latch) begin
                check_column();
            end
            if (overrun) begin
                overrun_seen = 1;
            end else if (overrun_seen) begin
                flag_error("overrun cleared without a reset");
            end
        end
        led_clk_q = led_clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int waits;
        int test_start;
        int tops_before;
        int columns_before;
        nrst     = 1'b0;
        hall_1   = 1'b1;
        hall_2   = 1'b1;
        wr_valid = 1'b0;
        wr       = '0;

        // Test 1 checks reset and loads the image
        test_start = errors;
        repeat (2) @(negedge clk);
        assert (!position_sync && !led_clk && !led_latch && !led_data && !overrun && !wr_ready)
        else flag_error("a control output was high during reset");
        nrst = 1'b1;
        for (int i = 0; i < `SLICES_PER_TURN; i++) begin
            image[i] = column_t'($random(seed));
        end
        for (int i = 0; i < `SLICES_PER_TURN; i++) begin
            write_column(slice_t'(i), image[i], waits);
            if (i == 0) begin
                assert (waits == 1)
                else flag_error($sformatf("wr_ready rose %0d cycles after reset", waits));
            end
            if ($unsigned($random(seed)) % 4 == 0) begin
                @(negedge clk);
            end
        end
        report_test(1, "reset and image load", test_start);

        // Test 2 runs half turns on hall_1
        test_start = errors;
        run_half_turns(1, 3, HALF_SLOW, PULSE_LOW);
        @(posedge clk);
        assert (saw_first_end) else flag_error("slice 127 was never reached");
        assert (columns > 0) else flag_error("no column was shifted");
        report_test(2, "hall_1 slices 0 to 127", test_start);
        @(negedge clk);

        // Test 3 runs half turns on hall_2
        test_start = errors;
        run_half_turns(2, 3, HALF_SLOW, PULSE_LOW);
        @(posedge clk);
        assert (saw_second_end) else flag_error("slice 255 was never reached");
        report_test(3, "hall_2 slices 128 to 255", test_start);
        // Test 4 covers the speed and spacing checks made during tests 2 and 3
        test_start = errors;
        assert (speed_checks > 0 && spacing_checks > 0)
        else flag_error("no speed or sync spacing was checked");
        report_test(4, "speed and sync spacing", test_start);
        @(negedge clk);

        // Test 5 holds a sensor low for many cycles
        test_start  = errors;
        tops_before = tops;
        run_half_turns(1, 1, HALF_SLOW, HOLD_LOW);
        @(posedge clk);
        assert (tops - tops_before == 1)
        else flag_error($sformatf("%0d tops from one held pulse", tops - tops_before));
        assert (!overrun_seen) else flag_error("overrun set at the slow rate");
        report_test(5, "sensor held low", test_start);
        @(negedge clk);

        // Test 6 runs fast turns that overrun the LED chain
        test_start     = errors;
        columns_before = columns;
        for (int i = 0; i < FAST_TURNS / 2; i++) begin
            run_half_turns(1, 1, HALF_FAST, PULSE_LOW);
            run_half_turns(2, 1, HALF_FAST, PULSE_LOW);
        end
        @(posedge clk);
        assert (overrun_seen) else flag_error("overrun never set at the fast rate");
        assert (columns > columns_before) else flag_error("no column shifted at the fast rate");
        report_test(6, "overrun at the fast rate", test_start);

        errors = errors + pov_display_i.checker_i.fail_count;
        $display("Summary: 6 tests, %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+source
source/pov_pkg.sv
source/hall_sensor.sv
source/stream_skid.sv
source/column_memory.sv
source/column_fetch.sv
source/led_shifter.sv
source/pov_display.sv
verification/pov_display_checker.sv
verification/pov_display_tb.sv
